/* Bender.yml */
package:
  name: tl_adapter

sources:
  - files:
      - tl_adapter_pkg.sv
      - tl_source_table.sv
      - tl_a_channel.sv
      - tl_d_channel.sv
      - tl_adapter_top.sv
  - target: test
    files:
      - tl_adapter_sva.sv
      - tl_adapter_tb.sv

/* sources.f */
tl_adapter_pkg.sv
tl_source_table.sv
tl_a_channel.sv
tl_d_channel.sv
tl_adapter_top.sv
tl_adapter_sva.sv
tl_adapter_tb.sv

/* tl_a_channel.sv */
/*
 * TL-UL A-channel stage
 * Turns a memory request into a registered A beat with QoS in a_user
 */
module tl_a_channel (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // Memory request port
    input  logic                                 mem_req_valid_i,
    output logic                                 mem_req_ready_o,
    input  tl_adapter_pkg::mem_req_t             mem_req_i,
    // Source table
    input  logic                                 slot_free_i,
    input  logic [tl_adapter_pkg::SOURCE_W-1:0]  free_source_i,
    output logic                                 alloc_o,
    output logic                                 alloc_write_o,
    output logic [tl_adapter_pkg::REQ_ID_W-1:0]  alloc_id_o,
    // TileLink A channel
    output logic                                 tl_a_valid_o,
    input  logic                                 tl_a_ready_i,
    output tl_adapter_pkg::tl_a_t                tl_a_o
);
    import tl_adapter_pkg::*;

    logic       a_valid_q;
    tl_a_t      a_q;
    tl_a_t      a_d;
    qos_class_e qos_class;

    // ==================================================
    // Handshake
    // ==================================================
    // Need a slot and room in the A register
    assign mem_req_ready_o = slot_free_i && (!a_valid_q || tl_a_ready_i);
    assign alloc_o         = mem_req_valid_i && mem_req_ready_o;
    assign alloc_write_o   = mem_req_i.write;
    assign alloc_id_o      = mem_req_i.id;

    // ==================================================
    // QoS classification
    // ==================================================
    // First match wins
    always_comb begin
        if (mem_req_i.addr < EXC_LIMIT) begin
            qos_class = QOS_EXCEPTION;
        end else if (!mem_req_i.write && (mem_req_i.addr[1:0] == 2'b00)) begin
            // Aligned reads are treated as fetches
            qos_class = QOS_INSTR_FETCH;
        end else if (mem_req_i.write || (mem_req_i.strb != {STRB_W{1'b1}})) begin
            qos_class = QOS_DATA_ACCESS;
        end else if (mem_req_i.addr >= PERIPH_BASE) begin
            qos_class = QOS_PERIPHERAL;
        end else begin
            qos_class = QOS_CACHE_FILL;
        end
    end

    // ==================================================
    // Beat construction
    // ==================================================
    always_comb begin
        a_d.source  = free_source_i;
        a_d.address = mem_req_i.addr;
        a_d.mask    = mem_req_i.strb;
        // Full strobes give PutFullData, anything less is partial
        if (!mem_req_i.write) begin
            a_d.opcode = TL_A_GET;
        end else if (mem_req_i.strb == {STRB_W{1'b1}}) begin
            a_d.opcode = TL_A_PUT_FULL;
        end else begin
            a_d.opcode = TL_A_PUT_PARTIAL;
        end
        // Reads carry no data
        a_d.data = mem_req_i.write ? mem_req_i.data : '0;
        // Log2 of bytes, out of range falls back to a word
        case (mem_req_i.size)
            3'd0, 3'd1, 3'd2, 3'd3: a_d.size = mem_req_i.size;
            default:                a_d.size = 3'd2;
        endcase
        // Upper user bits reserved
        a_d.user = {{(USER_W - QOS_W){1'b0}}, qos_level(qos_class)};
    end

    // Valid flag of the A register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            a_valid_q <= 1'b0;
        end else if (alloc_o) begin
            a_valid_q <= 1'b1;
        end else if (tl_a_ready_i) begin
            a_valid_q <= 1'b0;
        end
    end

    // Beat payload, held while stalled
    always_ff @(posedge clk_i) begin
        if (alloc_o) begin
            a_q <= a_d;
        end
    end

    assign tl_a_valid_o = a_valid_q;
    assign tl_a_o       = a_q;

endmodule

/* tl_adapter_pkg.sv */
/*
 * TL-UL manager adapter shared definitions
 * Bus widths, TileLink opcodes, QoS classes and port structs
 */
package tl_adapter_pkg;

    // ==================================================
    // Widths and limits
    // ==================================================
    localparam int unsigned ADDR_W    = 32;
    localparam int unsigned DATA_W    = 32;
    localparam int unsigned STRB_W    = DATA_W / 8;
    localparam int unsigned NUM_SLOTS = 16;
    localparam int unsigned SOURCE_W  = $clog2(NUM_SLOTS);
    localparam int unsigned REQ_ID_W  = 16;
    localparam int unsigned SIZE_W    = 3;
    localparam int unsigned USER_W    = 8;
    localparam int unsigned QOS_W     = 4;

    // Exception vectors live below this address
    localparam logic [ADDR_W-1:0] EXC_LIMIT   = 32'h0000_1000;
    // Peripheral space starts here and runs to the top
    localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'hF000_0000;

    // ==================================================
    // TileLink opcodes
    // ==================================================
    typedef enum logic [2:0] {
        TL_A_PUT_FULL    = 3'd0,
        TL_A_PUT_PARTIAL = 3'd1,
        TL_A_GET         = 3'd4
    } tl_a_opcode_e;

    typedef enum logic [2:0] {
        TL_D_ACCESS_ACK      = 3'd0,
        TL_D_ACCESS_ACK_DATA = 3'd1
    } tl_d_opcode_e;

    // QoS traffic classes, highest priority first
    typedef enum logic [2:0] {
        QOS_EXCEPTION,
        QOS_INSTR_FETCH,
        QOS_DATA_ACCESS,
        QOS_PERIPHERAL,
        QOS_CACHE_FILL
    } qos_class_e;

    // Priority level carried in the low half of a_user
    function automatic logic [QOS_W-1:0] qos_level(input qos_class_e cls);
        case (cls)
            QOS_EXCEPTION:   return 4'd15;
            QOS_INSTR_FETCH: return 4'd12;
            QOS_DATA_ACCESS: return 4'd8;
            QOS_PERIPHERAL:  return 4'd4;
            default:         return 4'd2;
        endcase
    endfunction

    // ==================================================
    // Port structs
    // ==================================================
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
        logic [STRB_W-1:0]   strb;
        logic                write;
        logic [SIZE_W-1:0]   size;
        logic [REQ_ID_W-1:0] id;
    } mem_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [REQ_ID_W-1:0] id;
        logic                error;
    } mem_rsp_t;

    typedef struct packed {
        tl_a_opcode_e        opcode;
        logic [SIZE_W-1:0]   size;
        logic [SOURCE_W-1:0] source;
        logic [ADDR_W-1:0]   address;
        logic [STRB_W-1:0]   mask;
        logic [DATA_W-1:0]   data;
        logic [USER_W-1:0]   user;
    } tl_a_t;

    typedef struct packed {
        tl_d_opcode_e        opcode;
        logic [SOURCE_W-1:0] source;
        logic [DATA_W-1:0]   data;
        logic                denied;
        logic                corrupt;
    } tl_d_t;

endpackage

/* tl_adapter_sva.sv */
/*
 * TileLink handshake assertions for the TL-UL adapter
 * Bound to the adapter top level
 */
module tl_adapter_sva (
    input logic                  clk_i,
    input logic                  rst_ni,
    input logic                  tl_a_valid_o,
    input logic                  tl_a_ready_i,
    input tl_adapter_pkg::tl_a_t tl_a_o,
    input logic                  tl_d_valid_i,
    input logic                  tl_d_ready_o,
    input tl_adapter_pkg::tl_d_t tl_d_i
);
    import tl_adapter_pkg::*;

    // Sources with an A beat sent and no D beat back yet
    logic [NUM_SLOTS-1:0] in_flight_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            in_flight_q <= '0;
        end else begin
            if (tl_a_valid_o && tl_a_ready_i) begin
                in_flight_q[tl_a_o.source] <= 1'b1;
            end
            if (tl_d_valid_i && tl_d_ready_o) begin
                in_flight_q[tl_d_i.source] <= 1'b0;
            end
        end
    end

    // ==================================================
    // Stability under stall
    // ==================================================
    a_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tl_a_valid_o && !tl_a_ready_i |=> tl_a_valid_o && $stable(tl_a_o))
        else $error("A beat dropped or changed while stalled");

    d_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tl_d_valid_i && !tl_d_ready_o |=> tl_d_valid_i && $stable(tl_d_i))
        else $error("D beat dropped or changed while stalled");

    // ==================================================
    // Field ranges
    // ==================================================
    // A new beat must use a slot that has no answer outstanding
    a_source_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tl_a_valid_o && tl_a_ready_i |-> !in_flight_q[tl_a_o.source])
        else $error("A source reused while still in flight");

    // Only the two access acks are legal on D
    d_opcode_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
        tl_d_valid_i |-> tl_d_i.opcode inside {TL_D_ACCESS_ACK, TL_D_ACCESS_ACK_DATA})
        else $error("Illegal D opcode");

endmodule

bind tl_adapter_top tl_adapter_sva u_sva (.*);

/* tl_adapter_tb.sv */
/*
 * TL-UL adapter testbench
 * Request table, out-of-order TileLink subordinate model, response scoreboard
 */
module tl_adapter_tb;
    import tl_adapter_pkg::*;

    localparam int NUM_ENTRIES = 22;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
        logic [STRB_W-1:0]   strb;
        logic                write;
        logic [SIZE_W-1:0]   size;
        logic [REQ_ID_W-1:0] id;
        logic                deny;
        tl_a_opcode_e        op;
        logic [QOS_W-1:0]    qos;
    } entry_t;

    // One accepted A beat waiting for its D answer
    typedef struct packed {
        logic [SOURCE_W-1:0] source;
        logic                is_read;
        logic                deny;
        logic [DATA_W-1:0]   data;
    } beat_t;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic mem_req_valid_i, mem_req_ready_o, mem_rsp_valid_o, mem_rsp_ready_i;
    logic tl_a_valid_o, tl_a_ready_i, tl_d_valid_i, tl_d_ready_o;
    mem_req_t mem_req_i;
    mem_rsp_t mem_rsp_o;
    tl_a_t    tl_a_o;
    tl_d_t    tl_d_i;

    entry_t            tab [NUM_ENTRIES];
    logic [DATA_W-1:0] exp_data [NUM_ENTRIES];
    int                rsp_seen [NUM_ENTRIES];
    // Expected memory (table order) and the subordinate's own memory
    logic [DATA_W-1:0] ref_mem [16];
    logic [DATA_W-1:0] sub_mem [16];
    logic              ref_wr [16];
    logic              sub_wr [16];
    beat_t             pend_q [$];
    logic [15:0]       lfsr;
    logic [15:0]       src_seen;
    logic              hold_rsp;
    int n_tab, a_count, rsp_total, value_errors, protocol_errors;

    tl_adapter_top u_dut (.*);

    always #10 clk_i = ~clk_i;

    // ==================================================
    // Helpers
    // ==================================================
    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    // Unwritten words read back a pattern of their word address
    function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5A5A_3C3C;
    endfunction

    // Table addresses are chosen so that bits 5:2 tell the words apart
    function automatic int word_index(input logic [ADDR_W-1:0] addr);
        return int'(addr[5:2]);
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old,
        input logic [DATA_W-1:0] wdata,
        input logic [STRB_W-1:0] strb
    );
        logic [DATA_W-1:0] res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_entry(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [STRB_W-1:0] strb, input logic write,
                             input logic [SIZE_W-1:0] size, input logic deny,
                             input tl_a_opcode_e op, input logic [QOS_W-1:0] qos);
        tab[n_tab] = '{addr, data, strb, write, size, 16'h3C00 + 16'(n_tab), deny, op, qos};
        n_tab++;
    endtask

    // ==================================================
    // Stimulus table
    // ==================================================
    // Columns: address, data, strobes, write, size, deny, opcode, QoS
    task automatic build_table();
        add_entry(32'h8000_0008, 32'h1111_2222, 4'hF, 1'b1, 3'd2, 1'b0, TL_A_PUT_FULL, 4'd8);
        add_entry(32'h8000_000C, 32'h3333_4444, 4'h3, 1'b1, 3'd1, 1'b0, TL_A_PUT_PARTIAL, 4'd8);
        add_entry(32'h8000_0008, 32'h0, 4'hF, 1'b0, 3'd2, 1'b0, TL_A_GET, 4'd12);
        add_entry(32'h8000_000C, 32'h0, 4'hF, 1'b0, 3'd2, 1'b0, TL_A_GET, 4'd12);
        add_entry(32'h0000_0100, 32'hCAFE_0001, 4'hF, 1'b1, 3'd2, 1'b0, TL_A_PUT_FULL, 4'd15);
        add_entry(32'h0000_0100, 32'h0, 4'hF, 1'b0, 3'd2, 1'b0, TL_A_GET, 4'd15);
        add_entry(32'h0000_0204, 32'h0, 4'hF, 1'b0, 3'd2, 1'b0, TL_A_GET, 4'd15);
        // Oversized requests fall back to a word
        add_entry(32'h8000_0010, 32'h5566_7788, 4'hC, 1'b1, 3'd5, 1'b0, TL_A_PUT_PARTIAL, 4'd8);
        add_entry(32'h8000_0010, 32'h0, 4'hF, 1'b0, 3'd7, 1'b0, TL_A_GET, 4'd12);
        add_entry(32'h2000_0016, 32'h0, 4'hF, 1'b0, 3'd0, 1'b0, TL_A_GET, 4'd2);
        add_entry(32'h2000_0016, 32'h0, 4'h3, 1'b0, 3'd1, 1'b0, TL_A_GET, 4'd8);
        add_entry(32'hF000_001A, 32'h0, 4'hF, 1'b0, 3'd0, 1'b0, TL_A_GET, 4'd4);
        add_entry(32'hF000_0018, 32'hDEAD_0018, 4'hF, 1'b1, 3'd2, 1'b0, TL_A_PUT_FULL, 4'd8);
        add_entry(32'hF000_0018, 32'h0, 4'hF, 1'b0, 3'd2, 1'b0, TL_A_GET, 4'd12);
        add_entry(32'h8000_0008, 32'h0, 4'hF, 1'b0, 3'd2, 1'b1, TL_A_GET, 4'd12);
        add_entry(32'h4000_001C, 32'h0A0B_0C0D, 4'h1, 1'b1, 3'd0, 1'b0, TL_A_PUT_PARTIAL, 4'd8);
        // Entry 16 waits while all slots are busy
        add_entry(32'h4000_001C, 32'h0, 4'hF, 1'b0, 3'd2, 1'b0, TL_A_GET, 4'd12);
        add_entry(32'h8000_0008, 32'h9999_8888, 4'hF, 1'b1, 3'd2, 1'b0, TL_A_PUT_FULL, 4'd8);
        add_entry(32'h8000_0008, 32'h0, 4'hF, 1'b0, 3'd2, 1'b0, TL_A_GET, 4'd12);
        add_entry(32'h1000_0026, 32'h0, 4'hF, 1'b0, 3'd4, 1'b0, TL_A_GET, 4'd2);
        add_entry(32'h4000_001C, 32'h7700_0000, 4'h8, 1'b1, 3'd0, 1'b0, TL_A_PUT_PARTIAL, 4'd8);
        add_entry(32'h0000_0FFE, 32'h0, 4'hF, 1'b0, 3'd1, 1'b1, TL_A_GET, 4'd15);
    endtask

    // ==================================================
    // Request driver
    // ==================================================
    task automatic drive_request(input int k);
        int                i;
        logic [DATA_W-1:0] old;
        @(negedge clk_i);
        mem_req_valid_i = 1'b1;
        mem_req_i       = '{tab[k].addr, tab[k].data, tab[k].strb, tab[k].write,
                            tab[k].size, tab[k].id};
        // Expected response follows table order
        i   = word_index(tab[k].addr);
        old = ref_wr[i] ? ref_mem[i] : fill_word(tab[k].addr);
        exp_data[k] = tab[k].write ? '0 : old;
        if (tab[k].write && !tab[k].deny) begin
            ref_mem[i] = merge_bytes(old, tab[k].data, tab[k].strb);
            ref_wr[i]  = 1'b1;
        end
    endtask

    task automatic wait_accept();
        do @(posedge clk_i); while (!mem_req_ready_o);
    endtask

    // ==================================================
    // TileLink subordinate model
    // ==================================================
    initial begin : subordinate
        beat_t             b;
        logic [DATA_W-1:0] old;
        int                i;
        int                v;
        int                pick;
        logic              d_busy;
        d_busy = 1'b0;
        @(posedge rst_ni);
        forever begin
            @(posedge clk_i);
            if (tl_a_valid_o && tl_a_ready_i) begin
                if (a_count >= NUM_ENTRIES) begin
                    protocol_errors++;
                    $display("More A beats arrived than requests were sent");
                end else begin
                    check_value("tl_a_o.opcode", tl_a_o.opcode, tab[a_count].op);
                    check_value("tl_a_o.address", tl_a_o.address, tab[a_count].addr);
                    check_value("tl_a_o.mask", tl_a_o.mask, tab[a_count].strb);
                    check_value("tl_a_o.size", tl_a_o.size,
                                (tab[a_count].size <= 3'd3) ? tab[a_count].size : 3'd2);
                    check_value("tl_a_o.data", tl_a_o.data,
                                tab[a_count].write ? tab[a_count].data : '0);
                    check_value("tl_a_o.user", tl_a_o.user, {4'b0, tab[a_count].qos});
                    if (hold_rsp && src_seen[tl_a_o.source]) begin
                        protocol_errors++;
                        $display("Source %0d was handed out twice", tl_a_o.source);
                    end
                    src_seen[tl_a_o.source] = 1'b1;
                    i   = word_index(tl_a_o.address);
                    old = sub_wr[i] ? sub_mem[i] : fill_word(tl_a_o.address);
                    // Write acks carry stale data, the adapter must zero it
                    b = '{tl_a_o.source, tl_a_o.opcode == TL_A_GET, tab[a_count].deny, old};
                    if (!b.is_read && !b.deny) begin
                        sub_mem[i] = merge_bytes(old, tl_a_o.data, tl_a_o.mask);
                        sub_wr[i]  = 1'b1;
                    end
                    pend_q.push_back(b);
                    a_count++;
                end
            end
            if (tl_d_valid_i && tl_d_ready_o) begin
                d_busy = 1'b0;
            end
            @(negedge clk_i);
            // Ready about three cycles in four
            take_bits(2, v);
            tl_a_ready_i = (v != 0);
            take_bits(2, v);
            mem_rsp_ready_i = (v != 0);
            if (!d_busy && !hold_rsp && pend_q.size() > 0) begin
                // Random pick gives out-of-order answers
                take_bits(4, v);
                pick = v % pend_q.size();
                b    = pend_q[pick];
                pend_q.delete(pick);
                tl_d_valid_i = 1'b1;
                tl_d_i = '{b.is_read ? TL_D_ACCESS_ACK_DATA : TL_D_ACCESS_ACK,
                           b.source, b.data, b.deny, 1'b0};
                d_busy = 1'b1;
            end else if (!d_busy) begin
                tl_d_valid_i = 1'b0;
            end
        end
    end

    // ==================================================
    // Response scoreboard
    // ==================================================
    always @(posedge clk_i) begin : rsp_monitor
        int idx;
        idx = -1;
        if (rst_ni && mem_rsp_valid_o && mem_rsp_ready_i) begin
            for (int k = 0; k < NUM_ENTRIES; k++) begin
                if (tab[k].id == mem_rsp_o.id) idx = k;
            end
            if (idx < 0) begin
                protocol_errors++;
                $display("Response with unknown request ID %h", mem_rsp_o.id);
            end else begin
                if (rsp_seen[idx] > 0) begin
                    protocol_errors++;
                    $display("Second response for request ID %h", mem_rsp_o.id);
                end
                check_value("mem_rsp_o.data", mem_rsp_o.data, exp_data[idx]);
                check_value("mem_rsp_o.error", mem_rsp_o.error, tab[idx].deny);
                rsp_seen[idx]++;
            end
            rsp_total++;
        end
    end

    // Watchdog
    initial begin
        repeat (NUM_ENTRIES * 200) @(posedge clk_i);
        $display("Watchdog expired before all responses came back");
        $display("Test failed");
        $finish;
    end

    initial begin : main
        {mem_req_valid_i, mem_rsp_ready_i, tl_a_ready_i, tl_d_valid_i} = '0;
        mem_req_i = '0;
        tl_d_i    = '0;
        lfsr      = 16'd17;
        src_seen  = '0;
        hold_rsp  = 1'b1;
        {n_tab, a_count, rsp_total, value_errors, protocol_errors} = '0;
        for (int i = 0; i < 16; i++) begin
            ref_wr[i] = 1'b0;
            sub_wr[i] = 1'b0;
        end
        for (int k = 0; k < NUM_ENTRIES; k++) rsp_seen[k] = 0;
        build_table();
        rst_ni = 1'b0;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        // Fill every slot while the model holds all answers
        for (int k = 0; k < NUM_SLOTS; k++) begin
            drive_request(k);
            wait_accept();
        end
        while (a_count < NUM_SLOTS) @(posedge clk_i);
        check_value("sources in use", src_seen, 16'hFFFF);
        drive_request(NUM_SLOTS);
        repeat (8) begin
            @(posedge clk_i);
            check_value("mem_req_ready_o", mem_req_ready_o, 1'b0);
        end
        hold_rsp = 1'b0;
        wait_accept();
        for (int k = NUM_SLOTS + 1; k < NUM_ENTRIES; k++) begin
            drive_request(k);
            wait_accept();
        end
        @(negedge clk_i);
        mem_req_valid_i = 1'b0;
        while (rsp_total < NUM_ENTRIES) @(posedge clk_i);
        // Room for a late duplicate to show up
        repeat (20) @(posedge clk_i);
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            if (rsp_seen[k] != 1) begin
                protocol_errors++;
                $display("Request %0d received %0d responses", k, rsp_seen[k]);
            end
        end
        $display("Value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* tl_adapter_top.sv */
/*
 * TL-UL manager adapter
 * Memory request/response port to TileLink A and D channels
 */
module tl_adapter_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    // Memory request
    input  logic                      mem_req_valid_i,
    output logic                      mem_req_ready_o,
    input  tl_adapter_pkg::mem_req_t  mem_req_i,
    // Memory response
    output logic                      mem_rsp_valid_o,
    input  logic                      mem_rsp_ready_i,
    output tl_adapter_pkg::mem_rsp_t  mem_rsp_o,
    // TileLink A channel
    output logic                      tl_a_valid_o,
    input  logic                      tl_a_ready_i,
    output tl_adapter_pkg::tl_a_t     tl_a_o,
    // TileLink D channel
    input  logic                      tl_d_valid_i,
    output logic                      tl_d_ready_o,
    input  tl_adapter_pkg::tl_d_t     tl_d_i
);
    import tl_adapter_pkg::*;

    // ==================================================
    // Internal links
    // ==================================================
    // Table to A side
    logic                slot_free;
    logic [SOURCE_W-1:0] free_source;
    // A side to table
    logic                alloc;
    logic                alloc_write;
    logic [REQ_ID_W-1:0] alloc_id;
    // D side and table lookup
    logic                d_fire;
    logic [SOURCE_W-1:0] d_source;
    logic [REQ_ID_W-1:0] rsp_id;
    logic                rsp_write;

    tl_source_table u_source_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .alloc_i       (alloc),
        .alloc_write_i (alloc_write),
        .alloc_id_i    (alloc_id),
        .free_i        (d_fire),
        .free_source_i (d_source),
        .slot_free_o   (slot_free),
        .free_source_o (free_source),
        .rsp_id_o      (rsp_id),
        .rsp_write_o   (rsp_write)
    );

    tl_a_channel u_a_channel (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .mem_req_valid_i (mem_req_valid_i),
        .mem_req_ready_o (mem_req_ready_o),
        .mem_req_i       (mem_req_i),
        .slot_free_i     (slot_free),
        .free_source_i   (free_source),
        .alloc_o         (alloc),
        .alloc_write_o   (alloc_write),
        .alloc_id_o      (alloc_id),
        .tl_a_valid_o    (tl_a_valid_o),
        .tl_a_ready_i    (tl_a_ready_i),
        .tl_a_o          (tl_a_o)
    );

    tl_d_channel u_d_channel (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .tl_d_valid_i    (tl_d_valid_i),
        .tl_d_ready_o    (tl_d_ready_o),
        .tl_d_i          (tl_d_i),
        .d_fire_o        (d_fire),
        .d_source_o      (d_source),
        .rsp_id_i        (rsp_id),
        .rsp_write_i     (rsp_write),
        .mem_rsp_valid_o (mem_rsp_valid_o),
        .mem_rsp_ready_i (mem_rsp_ready_i),
        .mem_rsp_o       (mem_rsp_o)
    );

endmodule

/* tl_d_channel.sv */
/*
 * TL-UL D-channel stage
 * Registers a D beat as a memory response, stalls D under back-pressure
 */
module tl_d_channel (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // TileLink D channel
    input  logic                                 tl_d_valid_i,
    output logic                                 tl_d_ready_o,
    input  tl_adapter_pkg::tl_d_t                tl_d_i,
    // Source table lookup
    output logic                                 d_fire_o,
    output logic [tl_adapter_pkg::SOURCE_W-1:0]  d_source_o,
    input  logic [tl_adapter_pkg::REQ_ID_W-1:0]  rsp_id_i,
    input  logic                                 rsp_write_i,
    // Memory response port
    output logic                                 mem_rsp_valid_o,
    input  logic                                 mem_rsp_ready_i,
    output tl_adapter_pkg::mem_rsp_t             mem_rsp_o
);
    import tl_adapter_pkg::*;

    logic     rsp_valid_q;
    mem_rsp_t rsp_q;

    // Accept when empty or emptying this cycle
    assign tl_d_ready_o = !rsp_valid_q || mem_rsp_ready_i;
    assign d_fire_o     = tl_d_valid_i && tl_d_ready_o;
    assign d_source_o   = tl_d_i.source;

    // ==================================================
    // Response register
    // ==================================================
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else if (d_fire_o) begin
            rsp_valid_q <= 1'b1;
        end else if (mem_rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (d_fire_o) begin
            // Write acks return zero data
            rsp_q.data  <= rsp_write_i ? '0 : tl_d_i.data;
            rsp_q.id    <= rsp_id_i;
            rsp_q.error <= tl_d_i.denied || tl_d_i.corrupt;
        end
    end

    assign mem_rsp_valid_o = rsp_valid_q;
    assign mem_rsp_o       = rsp_q;

endmodule

/* tl_source_table.sv */
/*
 * TL-UL source table
 * One slot per outstanding transaction, slot index is the source ID
 */
module tl_source_table (
    input  logic                                 clk_i,
    input  logic                                 rst_ni,
    // Allocation from the A side
    input  logic                                 alloc_i,
    input  logic                                 alloc_write_i,
    input  logic [tl_adapter_pkg::REQ_ID_W-1:0]  alloc_id_i,
    // Release from the D side
    input  logic                                 free_i,
    input  logic [tl_adapter_pkg::SOURCE_W-1:0]  free_source_i,
    // Next free slot
    output logic                                 slot_free_o,
    output logic [tl_adapter_pkg::SOURCE_W-1:0]  free_source_o,
    // Lookup result for the responding source
    output logic [tl_adapter_pkg::REQ_ID_W-1:0]  rsp_id_o,
    output logic                                 rsp_write_o
);
    import tl_adapter_pkg::*;

    // ==================================================
    // Slot storage
    // ==================================================
    // Busy flag per slot
    logic [NUM_SLOTS-1:0] valid_q;
    // Request ID and kind of each slot
    logic [REQ_ID_W-1:0]  id_q    [NUM_SLOTS];
    logic                 write_q [NUM_SLOTS];

    // ==================================================
    // Free slot search
    // ==================================================
    // Walk down so that the lowest free index wins
    always_comb begin
        slot_free_o   = 1'b0;
        free_source_o = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                slot_free_o   = 1'b1;
                free_source_o = SOURCE_W'(i);
            end
        end
    end

    // Busy flags
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else begin
            // Alloc only picks an idle slot, free only a busy one
            if (alloc_i) begin
                valid_q[free_source_o] <= 1'b1;
            end
            if (free_i) begin
                valid_q[free_source_i] <= 1'b0;
            end
        end
    end

    // Slot payload, written on allocation
    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            id_q[free_source_o]    <= alloc_id_i;
            write_q[free_source_o] <= alloc_write_i;
        end
    end

    // ==================================================
    // Response lookup
    // ==================================================
    // Same cycle as the D transfer
    assign rsp_id_o    = id_q[free_source_i];
    assign rsp_write_o = write_q[free_source_i];

endmodule
